//--- common/fir_pkg.sv
package fir_pkg;

    // Sample width on both input and output side
    localparam int DATA_W = 16;             // Signed samples and results

    // Coefficients are signed Q1.15
    localparam int COEFF_W = 16;

    // Accumulator width
    // 16 products of 16x16 bits need 32 + 4 bits, rest is headroom
    localparam int ACC_W = 40;

    // Arithmetic right shift from accumulator back to sample scale
    localparam int COEFF_FRAC = 15;         // Matches the Q1.15 fraction bits

    // Channel number width, enough for the default four cores
    localparam int CH_W = 2;

endpackage

//--- fir_core/fir_sample_ram.sv
`timescale 1ns/100ps

module fir_sample_ram
    import fir_pkg::*;
#(
    parameter int N_TAPS = 16                           // History depth, power of two
)(
    input  logic                        i_clk,
    input  logic                        i_we,           // Write strobe
    input  logic [$clog2(N_TAPS)-1:0]   i_addr,         // Shared read/write address
    input  logic signed [DATA_W-1:0]    i_wdata,
    output logic signed [DATA_W-1:0]    o_rdata         // Valid one clock after address
);

    // One channel's sample history, used as a circular buffer
    logic signed [DATA_W-1:0] mem [N_TAPS];

    // Single port, read-first
    // A read on the write clock returns the old word
    always_ff @(posedge i_clk) begin
        if (i_we) begin
            mem[i_addr] <= i_wdata;
        end
        o_rdata <= mem[i_addr];                         // Registered read
    end

endmodule

//--- fir_core/fir_coeff_rom.sv
`timescale 1ns/100ps

module fir_coeff_rom
    import fir_pkg::*;
#(
    parameter int N_TAPS = 16
)(
    input  logic                        i_clk,
    input  logic [$clog2(N_TAPS)-1:0]   i_addr,         // Tap index k
    output logic signed [COEFF_W-1:0]   o_coeff         // h[k], one clock later
);

    logic signed [COEFF_W-1:0] rom [N_TAPS];

    // Coefficient k weights the sample that is k steps old
    initial begin
        $readmemh("coeffs.mem", rom);
    end

    always_ff @(posedge i_clk) begin
        o_coeff <= rom[i_addr];
    end

endmodule

//--- fir_core/fir_core.sv
`timescale 1ns/100ps

module fir_core
    import fir_pkg::*;
#(
    parameter int N_TAPS = 16                           // Power of two, pointers wrap freely
)(
    input  logic                        i_clk,
    input  logic                        i_rst,
    input  logic                        i_start,        // One clock, sample valid with it
    input  logic signed [DATA_W-1:0]    i_sample,
    input  logic                        i_take,         // Collector has taken the result
    output logic                        o_idle,
    output logic                        o_result_valid,
    output logic signed [DATA_W-1:0]    o_result
);

    localparam int ADDR_W = $clog2(N_TAPS);

    // One-hot state bit positions
    localparam int S_IDLE  = 0;
    localparam int S_WRITE = 1;
    localparam int S_RUN   = 2;
    localparam int S_SCALE = 3;
    localparam int S_HOLD  = 4;

    // Saturation limits at accumulator width
    localparam logic signed [ACC_W-1:0] SAT_HI = (ACC_W'(1) <<< (DATA_W-1)) - ACC_W'(1);
    localparam logic signed [ACC_W-1:0] SAT_LO = -SAT_HI - 1;

    logic [4:0]                     state;
    logic [4:0]                     state_nxt;
    logic                           clearing;       // Zero sweep after reset
    logic [ADDR_W-1:0]              wr_ptr;         // Newest sample, or sweep address
    logic [ADDR_W-1:0]              rd_ptr;
    logic [ADDR_W-1:0]              cidx;           // Tap index
    logic [ADDR_W-1:0]              ram_addr;
    logic                           ram_we;
    logic signed [DATA_W-1:0]       ram_wdata;
    logic signed [DATA_W-1:0]       ram_rdata;
    logic signed [COEFF_W-1:0]      coeff;
    logic signed [DATA_W-1:0]       sample_q;
    logic                           mac_en;         // RAM/ROM data valid this clock
    logic signed [DATA_W+COEFF_W-1:0] product;
    logic signed [ACC_W-1:0]        acc;
    logic signed [ACC_W-1:0]        acc_nxt;
    logic signed [ACC_W-1:0]        acc_scaled;
    logic signed [DATA_W-1:0]       result_sat;

    assign o_idle         = state[S_IDLE] && !clearing;     // Busy during sweep too
    assign o_result_valid = state[S_HOLD];

    // Memory port sharing
    // RUN reads through rd_ptr, sweep and WRITE go through wr_ptr
    assign ram_addr  = state[S_RUN] ? rd_ptr : wr_ptr;
    assign ram_we    = clearing || state[S_WRITE];
    assign ram_wdata = clearing ? '0 : sample_q;

    fir_sample_ram #(
        .N_TAPS (N_TAPS)
    ) u_sample_ram (
        .i_clk   (i_clk),
        .i_we    (ram_we),
        .i_addr  (ram_addr),
        .i_wdata (ram_wdata),
        .o_rdata (ram_rdata)
    );

    fir_coeff_rom #(
        .N_TAPS (N_TAPS)
    ) u_coeff_rom (
        .i_clk   (i_clk),
        .i_addr  (cidx),
        .o_coeff (coeff)
    );

    // MAC, last product folded straight into the scale stage
    assign product = ram_rdata * coeff;
    assign acc_nxt = acc + product;                 // Sign extended to ACC_W

    // Shift back to sample scale and clamp
    always_comb begin
        acc_scaled = acc_nxt >>> COEFF_FRAC;
        if (acc_scaled > SAT_HI) begin
            result_sat = SAT_HI[DATA_W-1:0];        // 0x7FFF
        end else if (acc_scaled < SAT_LO) begin
            result_sat = SAT_LO[DATA_W-1:0];        // 0x8000
        end else begin
            result_sat = acc_scaled[DATA_W-1:0];
        end
    end

    // Next state
    always_comb begin
        state_nxt = '0;
        case (1'b1)
            state[S_IDLE]:  if (i_start && o_idle) state_nxt[S_WRITE] = 1'b1;
                            else                   state_nxt[S_IDLE]  = 1'b1;
            state[S_WRITE]: state_nxt[S_RUN] = 1'b1;
            state[S_RUN]:   if (cidx == ADDR_W'(N_TAPS-1)) state_nxt[S_SCALE] = 1'b1;
                            else                          state_nxt[S_RUN]   = 1'b1;
            state[S_SCALE]: state_nxt[S_HOLD] = 1'b1;
            state[S_HOLD]:  if (i_take) state_nxt[S_IDLE] = 1'b1;
                            else        state_nxt[S_HOLD] = 1'b1;
            default:        state_nxt[S_IDLE] = 1'b1;   // Recover from a bad encoding
        endcase
    end

    // Control state
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state    <= 5'b00001;
            clearing <= 1'b1;
            wr_ptr   <= '0;
            cidx     <= '0;
            mac_en   <= 1'b0;
        end else begin
            state  <= state_nxt;
            mac_en <= state[S_RUN];                 // Read data lands one clock later
            if (state[S_RUN]) begin
                cidx <= cidx + 1'b1;                // Wraps back to 0 after last tap
            end
            if (clearing) begin
                wr_ptr <= wr_ptr + 1'b1;            // Ends back at 0
                if (wr_ptr == ADDR_W'(N_TAPS-1)) begin
                    clearing <= 1'b0;
                end
            end else if (i_start && o_idle) begin
                wr_ptr <= wr_ptr - 1'b1;            // New slot for the incoming sample
            end
        end
    end

    // Datapath registers
    always_ff @(posedge i_clk) begin
        if (i_start && o_idle) begin
            sample_q <= i_sample;
            rd_ptr   <= wr_ptr - 1'b1;              // First read is the newest sample
        end else if (state[S_RUN]) begin
            rd_ptr <= rd_ptr + 1'b1;                // Step toward older samples
        end

        if (state[S_WRITE]) begin
            acc <= '0;
        end else if (mac_en) begin
            acc <= acc_nxt;
        end

        if (state[S_SCALE]) begin
            o_result <= result_sat;                 // Held through HOLD
        end
    end

endmodule

//--- source/sample_dispatcher.sv
`timescale 1ns/100ps

module sample_dispatcher
    import fir_pkg::*;
#(
    parameter int N_CORES = 4
)(
    input  logic                        i_clk,
    input  logic                        i_rst,
    input  logic                        i_in_valid,
    input  logic [CH_W-1:0]             i_in_channel,
    input  logic signed [DATA_W-1:0]    i_in_sample,
    input  logic [N_CORES-1:0]          i_core_idle,
    output logic                        o_in_ready,
    output logic [N_CORES-1:0]          o_core_start,   // One-hot, one clock
    output logic signed [DATA_W-1:0]    o_core_sample   // Broadcast to all cores
);

    logic [N_CORES-1:0] ch_sel;                         // Decoded channel
    logic [N_CORES-1:0] core_free;
    logic               accept;

    // Channel decode
    // Numbers past the last core select nothing
    always_comb begin
        for (int c = 0; c < N_CORES; c++) begin
            ch_sel[c] = (i_in_channel == CH_W'(c));
        end
    end

    // A core just started still shows idle for one clock, mask it
    assign core_free  = i_core_idle & ~o_core_start;
    assign o_in_ready = |(ch_sel & core_free);
    assign accept     = i_in_valid && o_in_ready;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_core_start <= '0;
        end else begin
            o_core_start <= accept ? ch_sel : '0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            o_core_sample <= i_in_sample;
        end
    end

endmodule

//--- source/result_collector.sv
`timescale 1ns/100ps

module result_collector
    import fir_pkg::*;
#(
    parameter int N_CORES     = 4,
    parameter int OUT_CREDITS = 4
)(
    input  logic                        i_clk,
    input  logic                        i_rst,
    input  logic [N_CORES-1:0]          i_result_valid,
    input  logic signed [DATA_W-1:0]    i_result [N_CORES],
    input  logic                        i_out_credit,   // One pulse returns one credit
    output logic [N_CORES-1:0]          o_take,
    output logic                        o_out_valid,
    output logic [CH_W-1:0]             o_out_channel,
    output logic signed [DATA_W-1:0]    o_out_sample
);

    localparam int CRED_W = $clog2(OUT_CREDITS+1);

    logic [CH_W-1:0]    last_ch;                        // Core served last
    logic [CH_W-1:0]    pick;
    logic               found;
    logic               send;
    logic [CRED_W-1:0]  credits;

    // Round-robin search, starting just after last_ch
    always_comb begin
        int idx;
        found = 1'b0;
        pick  = last_ch;
        for (int i = 1; i <= N_CORES; i++) begin
            idx = (int'(last_ch) + i) % N_CORES;
            if (!found && i_result_valid[idx]) begin
                found = 1'b1;
                pick  = CH_W'(idx);
            end
        end
    end

    assign send = found && (credits != '0);             // No credit, results wait in cores

    always_comb begin
        for (int c = 0; c < N_CORES; c++) begin
            o_take[c] = send && (pick == CH_W'(c));
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_out_valid <= 1'b0;
            last_ch     <= CH_W'(N_CORES-1);            // Core 0 served first
            credits     <= CRED_W'(OUT_CREDITS);
        end else begin
            o_out_valid <= send;
            if (send) begin
                last_ch <= pick;
            end
            // Send and return on the same clock cancel out
            case ({send, i_out_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // Output word, qualified by o_out_valid
    always_ff @(posedge i_clk) begin
        if (send) begin
            o_out_sample  <= i_result[pick];
            o_out_channel <= pick;
        end
    end

endmodule

//--- source/fir_bank_top.sv
`timescale 1ns/100ps

module fir_bank_top
    import fir_pkg::*;
#(
    parameter int N_CORES     = 4,                      // At most 2**CH_W
    parameter int N_TAPS      = 16,
    parameter int OUT_CREDITS = 4
)(
    input  logic                        i_clk,
    input  logic                        i_rst,
    input  logic                        i_in_valid,
    input  logic [CH_W-1:0]             i_in_channel,
    input  logic signed [DATA_W-1:0]    i_in_sample,
    input  logic                        i_out_credit,
    output logic                        o_in_ready,
    output logic                        o_out_valid,
    output logic [CH_W-1:0]             o_out_channel,
    output logic signed [DATA_W-1:0]    o_out_sample
);

    logic [N_CORES-1:0]         core_idle;
    logic [N_CORES-1:0]         core_start;
    logic signed [DATA_W-1:0]   core_sample;            // Shared by all cores
    logic [N_CORES-1:0]         res_valid;
    logic signed [DATA_W-1:0]   res_word [N_CORES];
    logic [N_CORES-1:0]         res_take;

    sample_dispatcher #(
        .N_CORES (N_CORES)
    ) u_dispatcher (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_in_valid    (i_in_valid),
        .i_in_channel  (i_in_channel),
        .i_in_sample   (i_in_sample),
        .i_core_idle   (core_idle),
        .o_in_ready    (o_in_ready),
        .o_core_start  (core_start),
        .o_core_sample (core_sample)
    );

    // One FIR engine per channel
    for (genvar c = 0; c < N_CORES; c++) begin : g_core
        fir_core #(
            .N_TAPS (N_TAPS)
        ) u_core (
            .i_clk          (i_clk),
            .i_rst          (i_rst),
            .i_start        (core_start[c]),
            .i_sample       (core_sample),
            .i_take         (res_take[c]),
            .o_idle         (core_idle[c]),
            .o_result_valid (res_valid[c]),
            .o_result       (res_word[c])
        );
    end

    result_collector #(
        .N_CORES     (N_CORES),
        .OUT_CREDITS (OUT_CREDITS)
    ) u_collector (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_result_valid (res_valid),
        .i_result       (res_word),
        .i_out_credit   (i_out_credit),
        .o_take         (res_take),
        .o_out_valid    (o_out_valid),
        .o_out_channel  (o_out_channel),
        .o_out_sample   (o_out_sample)
    );

endmodule

//--- verification/tb_fir_bank.sv
`timescale 1ns/100ps

module tb_fir_bank
    import fir_pkg::*;
();

    localparam int N_CORES     = 4;
    localparam int N_TAPS      = 16;
    localparam int OUT_CREDITS = 4;
    localparam int N_ENTRIES   = 152;               // 64 impulse, 32 clamp, 8 hold, 48 random
    localparam int READY_LIMIT = 400;               // Cycles allowed per input handshake
    localparam int DRAIN_LIMIT = 4000;
    localparam int CREDIT_GAP  = 3;                 // Consumer delay between credits
    localparam int HOLD_CYCLES = N_TAPS + 8;        // Every held result is ready by then

    logic                       i_clk;
    logic                       i_rst;
    logic                       i_in_valid;
    logic [CH_W-1:0]            i_in_channel;
    logic signed [DATA_W-1:0]   i_in_sample;
    logic                       i_out_credit = 1'b0;
    logic                       o_in_ready;
    logic                       o_out_valid;
    logic [CH_W-1:0]            o_out_channel;
    logic signed [DATA_W-1:0]   o_out_sample;

    // Stimulus table
    logic [CH_W-1:0]            tbl_ch     [N_ENTRIES];
    logic signed [DATA_W-1:0]   tbl_sample [N_ENTRIES];
    logic                       tbl_hold   [N_ENTRIES];     // Credit return paused
    int                         n_entries;

    // Reference model state and expected words per channel
    logic signed [COEFF_W-1:0]  coef [N_TAPS];
    logic signed [DATA_W-1:0]   hist [N_CORES][N_TAPS];     // hist[c][k] is k steps old
    logic signed [DATA_W-1:0]   exp_word [N_CORES][N_ENTRIES];
    int                         exp_head [N_CORES];
    int                         exp_tail [N_CORES];
    int                         n_clamp_hi;
    int                         n_clamp_lo;

    int                         seed;
    int                         errors = 0;                 // Wrong values
    int                         failures = 0;               // Timeouts and protocol faults
    int                         words_seen = 0;
    int                         owed = 0;                   // Credits not yet returned
    int                         outstanding = 0;            // Words sent minus credits back
    int                         max_outstanding = 0;
    int                         credit_wait = 0;
    int                         out_ch;
    logic                       hold_credits = 1'b0;
    logic                       inputs_started = 1'b0;

    fir_bank_top #(
        .N_CORES     (N_CORES),
        .N_TAPS      (N_TAPS),
        .OUT_CREDITS (OUT_CREDITS)
    ) i_fir_bank_top (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_in_valid    (i_in_valid),
        .i_in_channel  (i_in_channel),
        .i_in_sample   (i_in_sample),
        .i_out_credit  (i_out_credit),
        .o_in_ready    (o_in_ready),
        .o_out_valid   (o_out_valid),
        .o_out_channel (o_out_channel),
        .o_out_sample  (o_out_sample)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;                 // 20 ns period
    end

    task automatic check_value(input logic [15:0] got, input logic [15:0] exp,
                               input string what);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    // Shift a sample into the channel history, then sum, shift and clamp
    task automatic model_push(input int ch, input logic signed [DATA_W-1:0] s);
        longint acc;
        logic signed [DATA_W-1:0] res;
        for (int k = N_TAPS-1; k > 0; k--) begin
            hist[ch][k] = hist[ch][k-1];
        end
        hist[ch][0] = s;
        acc = 0;
        for (int k = 0; k < N_TAPS; k++) begin
            acc = acc + hist[ch][k] * coef[k];
        end
        acc = acc >>> COEFF_FRAC;
        if (acc > 32767) begin
            res = 16'sh7FFF;
            n_clamp_hi++;
        end else if (acc < -32768) begin
            res = 16'sh8000;
            n_clamp_lo++;
        end else begin
            res = acc[DATA_W-1:0];
        end
        exp_word[ch][exp_tail[ch]] = res;
        exp_tail[ch]++;
    endtask

    task automatic add_entry(input int ch, input int s, input logic hold);
        tbl_ch[n_entries]     = CH_W'(ch);
        tbl_sample[n_entries] = DATA_W'(s);
        tbl_hold[n_entries]   = hold;
        model_push(ch, DATA_W'(s));
        n_entries++;
    endtask

    task automatic build_table;
        int ch;
        int s;
        n_entries  = 0;
        n_clamp_hi = 0;
        n_clamp_lo = 0;
        for (int c = 0; c < N_CORES; c++) begin
            exp_head[c] = 0;
            exp_tail[c] = 0;
            for (int k = 0; k < N_TAPS; k++) begin
                hist[c][k] = '0;                    // Core history starts cleared
            end
        end
        // Impulse on every channel, interleaved
        for (int r = 0; r < N_TAPS; r++) begin
            for (int c = 0; c < N_CORES; c++) begin
                add_entry(c, (r == 0) ? 32'h7FFF : 0, 1'b0);
            end
        end
        // Full-scale runs, positive on 2 and negative on 3
        for (int r = 0; r < N_TAPS; r++) begin
            add_entry(2, 32'h7FFF, 1'b0);
            add_entry(3, 32'h8000, 1'b0);
        end
        // Two per channel with credits held, four words wait in the cores
        for (int r = 0; r < 2; r++) begin
            for (int c = 0; c < N_CORES; c++) begin
                s = $random(seed);
                add_entry(c, s, 1'b1);
            end
        end
        for (int r = 0; r < 48; r++) begin
            ch = $unsigned($random(seed)) % N_CORES;
            s  = $random(seed);
            add_entry(ch, s, 1'b0);
        end
    endtask

    // Wait until target words are out and every credit went back
    task automatic wait_outputs(input int target);
        int cycles;
        cycles = 0;
        while ((words_seen < target || owed != 0) && cycles < DRAIN_LIMIT) begin
            @(posedge i_clk);
            cycles++;
        end
        if (words_seen < target || owed != 0) begin
            failures++;
            $display("Timeout waiting for %0d output words, only %0d arrived", target, words_seen);
        end
    endtask

    // Credits still held, results past the credit count must stay in the cores
    task automatic watch_credit_hold(input int base);
        int cycles;
        cycles = 0;
        while (cycles < HOLD_CYCLES) begin
            @(posedge i_clk);
            cycles++;
        end
        check_value(16'(words_seen - base), 16'(OUT_CREDITS), "words sent while credits held");
    endtask

    task automatic send_entry(input int idx);
        int cycles;
        hold_credits   <= tbl_hold[idx];
        inputs_started <= 1'b1;
        i_in_valid     <= 1'b1;
        i_in_channel   <= tbl_ch[idx];
        i_in_sample    <= tbl_sample[idx];
        @(posedge i_clk);
        cycles = 1;
        while (!o_in_ready && cycles < READY_LIMIT) begin   // Ready as seen by the DUT
            @(posedge i_clk);
            cycles++;
        end
        if (!o_in_ready) begin
            failures++;
            $display("Timeout: input entry %0d on channel %0d was never accepted",
                     idx, tbl_ch[idx]);
        end
    endtask

    // Output monitor and credit return
    always @(posedge i_clk) begin
        i_out_credit <= 1'b0;
        if (!i_rst) begin
            if (o_out_valid) begin
                words_seen++;
                owed++;
                outstanding++;
                if (outstanding > max_outstanding) begin
                    max_outstanding = outstanding;
                end
                if (outstanding > OUT_CREDITS) begin
                    failures++;
                    $display("More than %0d words sent without credit at %0t ns",
                             OUT_CREDITS, $time);
                end
                out_ch = int'(o_out_channel);
                if (!inputs_started) begin
                    failures++;
                    $display("Output word at %0t ns before any input was sent", $time);
                end else if (exp_head[out_ch] == exp_tail[out_ch]) begin
                    failures++;
                    $display("Unexpected extra output on channel %0d at %0t ns", out_ch, $time);
                end else begin
                    check_value(o_out_sample, exp_word[out_ch][exp_head[out_ch]],
                                $sformatf("channel %0d word %0d", out_ch, exp_head[out_ch]));
                    exp_head[out_ch]++;
                end
            end
            if (i_out_credit) begin
                outstanding--;                      // DUT counts it on this edge
            end
            if (credit_wait > 0) begin
                credit_wait--;
            end else if (owed > 0 && !hold_credits) begin
                i_out_credit <= 1'b1;
                owed--;
                credit_wait = CREDIT_GAP;
            end
        end
    end

    initial begin
        int cycles;
        int hold_base;
        $timeformat(-9, 0, "", 0);                  // %t in whole ns
        seed         = 80528;
        hold_base    = 0;
        i_rst        <= 1'b1;
        i_in_valid   <= 1'b0;
        i_in_channel <= '0;
        i_in_sample  <= '0;
        $readmemh("coeffs.mem", coef);
        build_table();
        if (n_clamp_hi == 0 || n_clamp_lo == 0) begin
            failures++;
            $display("Saturation stimulus never drives the model into both clamps");
        end

        repeat (16) @(posedge i_clk);
        i_rst <= 1'b0;
        cycles = 0;
        while (!o_in_ready && cycles < READY_LIMIT) begin  // History sweep runs here
            @(posedge i_clk);
            cycles++;
            check_value(16'(o_out_valid), 16'h0, "o_out_valid before first input");
        end
        if (!o_in_ready) begin
            failures++;
            $display("Timeout: input ready never rose after reset");
        end

        for (int i = 0; i < n_entries; i++) begin
            if (tbl_hold[i] && i > 0 && !tbl_hold[i-1]) begin
                i_in_valid <= 1'b0;
                wait_outputs(i);                    // Start the hold with full credits
                hold_base = words_seen;
            end else if (!tbl_hold[i] && i > 0 && tbl_hold[i-1]) begin
                i_in_valid <= 1'b0;
                watch_credit_hold(hold_base);       // Held results pile up in the cores
            end
            send_entry(i);
        end
        i_in_valid   <= 1'b0;
        hold_credits <= 1'b0;
        wait_outputs(n_entries);
        check_value(16'(max_outstanding), 16'(OUT_CREDITS), "peak words without credit");

        $display("Mismatches: %0d, other failures: %0d", errors, failures);
        if (errors == 0 && failures == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- coeffs.mem
// One signed Q1.15 coefficient per line, h[0] first (weights the newest sample)
0400
0800
1000
1800
2000
2800
3000
3800
3800
3000
2800
2000
1800
1000
0800
0400

//--- sim.f
common/fir_pkg.sv
fir_core/fir_sample_ram.sv
fir_core/fir_coeff_rom.sv
fir_core/fir_core.sv
source/sample_dispatcher.sv
source/result_collector.sv
source/fir_bank_top.sv
verification/tb_fir_bank.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the FIR bank testbench with Verilator.
# Runs from the project root so coeffs.mem is found.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f sim.f --top-module tb_fir_bank -Mdir obj_dir -o tb_fir_bank
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_fir_bank > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Checks failed" "$LOG"; then
    echo "Simulation reported failures"
    exit 1
fi

echo "Simulation finished without failures"
exit 0
